/* design/buf_pkg.sv */
`default_nettype none

package buf_pkg;

    // word layout, bit 5 picks the destination
    localparam int word_width = 6;
    localparam int dest_bit = 5;

    // fifo geometry
    localparam int ptr_width = 3;
    localparam int fifo_depth = 8;

    // count needs one extra bit to hold a full fifo
    localparam int count_width = 4;

    // threshold reset values, same for both destinations
    localparam logic [count_width-1:0] af_default = 4'd6;
    localparam logic [count_width-1:0] ae_default = 4'd2;

    // decoded destination of a routed word
    typedef enum logic {
        DEST_D0 = 1'b0,
        DEST_D1 = 1'b1
    } dest_e;

    // which threshold register a config write targets
    typedef enum logic [1:0] {
        SEL_AF_D0 = 2'd0,
        SEL_AE_D0 = 2'd1,
        SEL_AF_D1 = 2'd2,
        SEL_AE_D1 = 2'd3
    } cfg_sel_e;

endpackage

`default_nettype wire

/* design/ram_memory.sv */
`default_nettype none

// storage behind one destination fifo
module ram_memory (
    input  wire logic                           clk,
    input  wire logic                           write,
    input  wire logic [buf_pkg::ptr_width-1:0]  wr_ptr,
    input  wire logic [buf_pkg::ptr_width-1:0]  rd_ptr,
    input  wire logic [buf_pkg::word_width-1:0] data_in,
    output logic      [buf_pkg::word_width-1:0] data_out
);

    import buf_pkg::*;

    // one entry per fifo slot
    logic [word_width-1:0] mem [fifo_depth];

    // synchronous write by pointer
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // combinational read so the fifo can register it on pop
    assign data_out = mem[rd_ptr];

endmodule

`default_nettype wire

/* design/dest_fifo.sv */
`default_nettype none

// eight-entry destination fifo with empty, pause and error status
module dest_fifo (
    input  wire logic                            clk,
    input  wire logic                            reset_L,
    input  wire logic                            push,
    input  wire logic                            pop,
    input  wire logic [buf_pkg::word_width-1:0]  wr_data,
    input  wire logic [buf_pkg::count_width-1:0] af,
    input  wire logic [buf_pkg::count_width-1:0] ae,
    output logic      [buf_pkg::word_width-1:0]  data_out,
    output logic                                 empty,
    output logic                                 pause,
    output logic                                 error
);

    import buf_pkg::*;

    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;      // words currently held
    logic [word_width-1:0]  ram_rd_data;
    logic                   full;
    logic                   push_ok;    // push that actually stores
    logic                   pop_ok;     // pop that actually reads
    logic                   above_af;
    logic                   in_ae_band;

    ram_memory u_ram (
        .clk      (clk),
        .write    (push_ok),
        .wr_ptr   (wr_ptr),
        .rd_ptr   (rd_ptr),
        .data_in  (wr_data),
        .data_out (ram_rd_data)
    );

    // status straight from the count
    assign empty = (count == '0);
    assign full  = (count == count_width'(fifo_depth));

    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // almost-empty band wins over almost-full
    assign above_af   = (count >= af);
    assign in_ae_band = !empty && (count <= ae);
    assign pause      = above_af && !in_ae_band;

    // one-cycle flag, no state kept
    assign error = (push && full) || (pop && empty);

    // write side
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
        end else if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at 8
        end
    end

    // read side, data_out holds between pops
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            rd_ptr   <= '0;
            data_out <= '0;
        end else if (pop_ok) begin
            rd_ptr   <= rd_ptr + 1'b1;
            data_out <= ram_rd_data;   // oldest word
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            count <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push with pop
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/thresh_regs.sv */
`default_nettype none

// almost-full / almost-empty thresholds for both fifos
module thresh_regs (
    input  wire logic                            clk,
    input  wire logic                            reset_L,
    input  wire logic                            cfg_write,
    input  wire buf_pkg::cfg_sel_e               cfg_sel,
    input  wire logic [buf_pkg::count_width-1:0] cfg_data,
    output logic      [buf_pkg::count_width-1:0] af_d0,
    output logic      [buf_pkg::count_width-1:0] ae_d0,
    output logic      [buf_pkg::count_width-1:0] af_d1,
    output logic      [buf_pkg::count_width-1:0] ae_d1
);

    import buf_pkg::*;

    logic [count_width-1:0] af_d0_q;
    logic [count_width-1:0] ae_d0_q;
    logic [count_width-1:0] af_d1_q;
    logic [count_width-1:0] ae_d1_q;

    // values above the depth are kept as written
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            af_d0_q <= af_default;
            ae_d0_q <= ae_default;
            af_d1_q <= af_default;
            ae_d1_q <= ae_default;
        end else if (cfg_write) begin
            case (cfg_sel)
                SEL_AF_D0: af_d0_q <= cfg_data;
                SEL_AE_D0: ae_d0_q <= cfg_data;
                SEL_AF_D1: af_d1_q <= cfg_data;
                SEL_AE_D1: ae_d1_q <= cfg_data;
            endcase
        end
    end

    // registers feed the pause compare directly
    assign af_d0 = af_d0_q;
    assign ae_d0 = ae_d0_q;
    assign af_d1 = af_d1_q;
    assign ae_d1 = ae_d1_q;

endmodule

`default_nettype wire

/* design/dest_router.sv */
`default_nettype none

// input register stage that steers each word to d0 or d1
module dest_router (
    input  wire logic                           clk,
    input  wire logic                           reset_L,
    input  wire logic                           in_push,
    input  wire logic [buf_pkg::word_width-1:0] in_data,
    output logic                                push_d0,
    output logic                                push_d1,
    output logic      [buf_pkg::word_width-1:0] wr_data
);

    import buf_pkg::*;

    logic                  push_q;
    logic [word_width-1:0] data_q;
    dest_e                 dest;

    // registered push strobe
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            push_q <= 1'b0;
        end else begin
            push_q <= in_push;
        end
    end

    // registered word
    always_ff @(posedge clk) begin
        data_q <= in_data;
    end

    assign dest = dest_e'(data_q[dest_bit]);

    // exactly one fifo sees the strobe
    assign push_d0 = push_q && (dest == DEST_D0);
    assign push_d1 = push_q && (dest == DEST_D1);

    assign wr_data = data_q;   // full word including the dest bit

endmodule

`default_nettype wire

/* design/buf_top.sv */
`default_nettype none

// two-destination packet buffer
module buf_top (
    input  wire logic                            clk,
    input  wire logic                            reset_L,
    input  wire logic                            in_push,
    input  wire logic [buf_pkg::word_width-1:0]  in_data,
    input  wire logic                            pop_d0,
    input  wire logic                            pop_d1,
    input  wire logic                            cfg_write,
    input  wire buf_pkg::cfg_sel_e               cfg_sel,
    input  wire logic [buf_pkg::count_width-1:0] cfg_data,
    output logic      [buf_pkg::word_width-1:0]  data_out_d0,
    output logic      [buf_pkg::word_width-1:0]  data_out_d1,
    output logic                                 empty_d0,
    output logic                                 empty_d1,
    output logic                                 pause_d0,
    output logic                                 pause_d1,
    output logic                                 error_d0,
    output logic                                 error_d1
);

    import buf_pkg::*;

    // router to fifos
    logic                   push_d0;
    logic                   push_d1;
    logic [word_width-1:0]  wr_data;   // shared by both fifos

    // thresholds
    logic [count_width-1:0] af_d0;
    logic [count_width-1:0] ae_d0;
    logic [count_width-1:0] af_d1;
    logic [count_width-1:0] ae_d1;

    dest_router u_router (
        .clk     (clk),
        .reset_L (reset_L),
        .in_push (in_push),
        .in_data (in_data),
        .push_d0 (push_d0),
        .push_d1 (push_d1),
        .wr_data (wr_data)
    );

    thresh_regs u_thresh (
        .clk       (clk),
        .reset_L   (reset_L),
        .cfg_write (cfg_write),
        .cfg_sel   (cfg_sel),
        .cfg_data  (cfg_data),
        .af_d0     (af_d0),
        .ae_d0     (ae_d0),
        .af_d1     (af_d1),
        .ae_d1     (ae_d1)
    );

    dest_fifo u_fifo_d0 (
        .clk      (clk),
        .reset_L  (reset_L),
        .push     (push_d0),
        .pop      (pop_d0),
        .wr_data  (wr_data),
        .af       (af_d0),
        .ae       (ae_d0),
        .data_out (data_out_d0),
        .empty    (empty_d0),
        .pause    (pause_d0),
        .error    (error_d0)
    );

    dest_fifo u_fifo_d1 (
        .clk      (clk),
        .reset_L  (reset_L),
        .push     (push_d1),
        .pop      (pop_d1),
        .wr_data  (wr_data),
        .af       (af_d1),
        .ae       (ae_d1),
        .data_out (data_out_d1),
        .empty    (empty_d1),
        .pause    (pause_d1),
        .error    (error_d1)
    );

endmodule

`default_nettype wire

/* dv/tb_buf_top.sv */
`default_nettype none

module tb_buf_top;

    import buf_pkg::*;

    // stimulus table operations
    typedef enum logic [2:0] {
        OP_IDLE,
        OP_PUSH,        // arg picks the destination
        OP_POP0,
        OP_POP1,
        OP_PUSH_POP,    // push and pop on the fifo named by arg
        OP_CFG          // arg is the threshold value
    } op_e;

    typedef struct packed {
        op_e                    op;
        cfg_sel_e               sel;
        logic [count_width-1:0] arg;
        logic [7:0]             reps;
    } row_t;

    logic                   clk = 1'b0;
    logic                   reset_L;
    logic                   in_push;
    logic [word_width-1:0]  in_data;
    logic                   pop_d0;
    logic                   pop_d1;
    logic                   cfg_write;
    cfg_sel_e               cfg_sel;
    logic [count_width-1:0] cfg_data;
    logic [word_width-1:0]  data_out_d0;
    logic [word_width-1:0]  data_out_d1;
    logic                   empty_d0;
    logic                   empty_d1;
    logic                   pause_d0;
    logic                   pause_d1;
    logic                   error_d0;
    logic                   error_d1;

    row_t                   rows [$];
    logic [31:0]            lfsr;
    int                     limit = 0;       // watchdog time, set once the table is loaded
    int                     total_cycles;
    int                     word_errs;
    int                     flag_errs;
    int                     count_errs;

    // reference model
    logic [word_width-1:0]  ref_q0 [$];
    logic [word_width-1:0]  ref_q1 [$];
    logic [count_width-1:0] m_cnt [2];
    logic [word_width-1:0]  m_data [2];
    logic [count_width-1:0] m_af [2];
    logic [count_width-1:0] m_ae [2];
    logic                   m_pend [2];      // word sitting in the router stage
    logic [word_width-1:0]  m_pend_word;

    buf_top u_buf_top (
        .clk         (clk),
        .reset_L     (reset_L),
        .in_push     (in_push),
        .in_data     (in_data),
        .pop_d0      (pop_d0),
        .pop_d1      (pop_d1),
        .cfg_write   (cfg_write),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .data_out_d0 (data_out_d0),
        .data_out_d1 (data_out_d1),
        .empty_d0    (empty_d0),
        .empty_d1    (empty_d1),
        .pause_d0    (pause_d0),
        .pause_d1    (pause_d1),
        .error_d0    (error_d0),
        .error_d1    (error_d1)
    );

    always #5 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic pause_expected(input logic [count_width-1:0] cnt,
                                            input logic [count_width-1:0] af,
                                            input logic [count_width-1:0] ae);
        if (cnt != 0 && cnt <= ae) begin
            return 1'b0;   // almost-empty band
        end
        return (cnt >= af);
    endfunction

    task check_word(input string name, input logic [word_width-1:0] exp,
                    input logic [word_width-1:0] act);
        if (act !== exp) begin
            $display("mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
            word_errs++;
        end
    endtask

    task check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at time %0t: %s expected %b got %b", $time, name, exp, act);
            flag_errs++;
        end
    endtask

    task check_count(input string name, input logic [count_width-1:0] exp,
                     input logic [count_width-1:0] act);
        if (act !== exp) begin
            $display("mismatch at time %0t: %s expected %0d got %0d", $time, name, exp, act);
            count_errs++;
        end
    endtask

    task add_row(input op_e op, input cfg_sel_e sel, input int arg, input int reps);
        row_t r;
        r.op   = op;
        r.sel  = sel;
        r.arg  = count_width'(arg);
        r.reps = 8'(reps);
        rows.push_back(r);
    endtask

    // random low bits, destination bit from the table
    task make_word(input logic dest, output logic [word_width-1:0] w);
        int b;
        w = '0;
        for (b = 0; b < dest_bit; b++) begin
            lfsr = lfsr_step(lfsr);
            w[b] = lfsr[0];
        end
        w[dest_bit] = dest;
    endtask

    task load_table;
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);       // state right after reset
        add_row(OP_PUSH, SEL_AF_D0, 0, 3);
        add_row(OP_PUSH, SEL_AF_D0, 1, 3);
        add_row(OP_PUSH, SEL_AF_D0, 0, 1);
        add_row(OP_PUSH, SEL_AF_D0, 1, 1);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP0, SEL_AF_D0, 0, 4);
        add_row(OP_POP1, SEL_AF_D0, 0, 4);
        // default thresholds, count walks up to 7 and back
        add_row(OP_PUSH, SEL_AF_D0, 0, 7);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP0, SEL_AF_D0, 0, 7);
        // ae not below af on d0
        add_row(OP_CFG, SEL_AF_D0, 4, 1);
        add_row(OP_CFG, SEL_AE_D0, 5, 1);
        add_row(OP_PUSH, SEL_AF_D0, 0, 6);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP0, SEL_AF_D0, 0, 6);
        add_row(OP_CFG, SEL_AF_D1, 3, 1);
        add_row(OP_CFG, SEL_AE_D1, 1, 1);
        add_row(OP_PUSH, SEL_AF_D0, 1, 5);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP1, SEL_AF_D0, 0, 5);
        // overflow, ninth word dropped
        add_row(OP_PUSH, SEL_AF_D0, 1, 9);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP1, SEL_AF_D0, 0, 8);
        // underflow
        add_row(OP_POP0, SEL_AF_D0, 0, 2);
        add_row(OP_POP1, SEL_AF_D0, 0, 1);
        add_row(OP_IDLE, SEL_AF_D0, 0, 1);
        // push with pop on a busy fifo
        add_row(OP_PUSH, SEL_AF_D0, 0, 3);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_PUSH_POP, SEL_AF_D0, 0, 5);
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP0, SEL_AF_D0, 0, 4);
        add_row(OP_PUSH_POP, SEL_AF_D0, 1, 3);   // first pop hits an empty d1
        add_row(OP_IDLE, SEL_AF_D0, 0, 2);
        add_row(OP_POP1, SEL_AF_D0, 0, 3);
        add_row(OP_IDLE, SEL_AF_D0, 0, 3);
    endtask

    task check_dest(input int f, input logic pop, input logic [word_width-1:0] dout,
                    input logic empty, input logic pause, input logic error,
                    input logic [count_width-1:0] cnt_act, input string sfx);
        int   sz;
        logic exp_err;
        sz = (f == 0) ? ref_q0.size() : ref_q1.size();
        exp_err = (m_pend[f] && sz == fifo_depth) || (pop && sz == 0);
        check_count({"count_", sfx}, m_cnt[f], cnt_act);
        check_flag({"empty_", sfx}, (m_cnt[f] == 0), empty);
        check_flag({"pause_", sfx}, pause_expected(m_cnt[f], m_af[f], m_ae[f]), pause);
        check_flag({"error_", sfx}, exp_err, error);
        check_word({"data_out_", sfx}, m_data[f], dout);
    endtask

    // advance the model across the coming rising edge
    task update_model(input logic pop0, input logic pop1, input logic push,
                      input logic [word_width-1:0] w, input row_t r);
        int                    f;
        int                    sz;
        logic                  pop;
        logic                  push_acc;
        logic                  pop_acc;
        logic [word_width-1:0] oldest;
        for (f = 0; f < 2; f++) begin
            pop = (f == 0) ? pop0 : pop1;
            sz  = (f == 0) ? ref_q0.size() : ref_q1.size();
            push_acc = m_pend[f] && (sz < fifo_depth);   // full drops even with a pop
            pop_acc  = pop && (sz > 0);
            if (pop_acc) begin
                if (f == 0) begin
                    oldest = ref_q0.pop_front();
                end else begin
                    oldest = ref_q1.pop_front();
                end
                m_data[f] = oldest;
            end
            if (push_acc) begin
                if (f == 0) begin
                    ref_q0.push_back(m_pend_word);
                end else begin
                    ref_q1.push_back(m_pend_word);
                end
            end
            if (push_acc && !pop_acc) begin
                m_cnt[f] = m_cnt[f] + 1'b1;
            end else if (pop_acc && !push_acc) begin
                m_cnt[f] = m_cnt[f] - 1'b1;
            end
        end
        if (r.op == OP_CFG) begin
            case (r.sel)
                SEL_AF_D0: m_af[0] = r.arg;
                SEL_AE_D0: m_ae[0] = r.arg;
                SEL_AF_D1: m_af[1] = r.arg;
                default:   m_ae[1] = r.arg;
            endcase
        end
        m_pend[0]   = push && !w[dest_bit];
        m_pend[1]   = push && w[dest_bit];
        m_pend_word = w;
    endtask

    task apply_cycle(input row_t r);
        logic                  push;
        logic                  pop0;
        logic                  pop1;
        logic [word_width-1:0] w;
        push = (r.op == OP_PUSH) || (r.op == OP_PUSH_POP);
        pop0 = (r.op == OP_POP0) || (r.op == OP_PUSH_POP && !r.arg[0]);
        pop1 = (r.op == OP_POP1) || (r.op == OP_PUSH_POP && r.arg[0]);
        w = '0;
        if (push) begin
            make_word(r.arg[0], w);
        end
        @(negedge clk);
        in_push   = push;
        in_data   = w;
        pop_d0    = pop0;
        pop_d1    = pop1;
        cfg_write = (r.op == OP_CFG);
        cfg_sel   = r.sel;
        cfg_data  = r.arg;
        #1;   // let the combinational error settle
        check_dest(0, pop0, data_out_d0, empty_d0, pause_d0, error_d0,
                   u_buf_top.u_fifo_d0.count, "d0");
        check_dest(1, pop1, data_out_d1, empty_d1, pause_d1, error_d1,
                   u_buf_top.u_fifo_d1.count, "d1");
        update_model(pop0, pop1, push, w, r);
    endtask

    initial begin
        reset_L   = 1'b0;
        in_push   = 1'b0;
        in_data   = '0;
        pop_d0    = 1'b0;
        pop_d1    = 1'b0;
        cfg_write = 1'b0;
        cfg_sel   = SEL_AF_D0;
        cfg_data  = '0;
        lfsr      = 32'h4f4b;
        word_errs  = 0;
        flag_errs  = 0;
        count_errs = 0;
        for (int f = 0; f < 2; f++) begin
            m_cnt[f]  = '0;
            m_data[f] = '0;
            m_af[f]   = af_default;
            m_ae[f]   = ae_default;
            m_pend[f] = 1'b0;
        end
        m_pend_word = '0;
        load_table();
        total_cycles = 0;
        foreach (rows[i]) begin
            total_cycles += rows[i].reps;
        end
        limit = total_cycles * 10 + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_L = 1'b1;
        foreach (rows[i]) begin
            for (int n = 0; n < rows[i].reps; n++) begin
                apply_cycle(rows[i]);
            end
        end
        $display("error counts: word %0d, flag %0d, count %0d", word_errs, flag_errs,
                 count_errs);
        if (word_errs + flag_errs + count_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (limit != 0);
        #(limit);
        $display("timeout: the run did not finish within %0d time units", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
design/buf_pkg.sv
design/ram_memory.sv
design/dest_fifo.sv
design/thresh_regs.sv
design/dest_router.sv
design/buf_top.sv
dv/tb_buf_top.sv
